/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_adc_acq
DUT_TOP   ?= adc_acq_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* acq_burst_timer.sv */
`timescale 1ns/100ps

module acq_burst_timer
    import acq_pkg::*;
#(
    parameter int BURST_W = 23,
    parameter int GAP_W   = 22
) (
    input  logic               adc_clk,
    input  logic               dummy_dat_reset,
    input  fill_type_t         fill_type,
    input  logic [BURST_W-1:0] num_muon_bursts,
    input  logic [BURST_W-1:0] num_laser_bursts,
    input  logic [BURST_W-1:0] num_ped_bursts,
    input  logic [GAP_W-1:0]   waveform_gap,     // idle cycles between waveforms
    input  logic               load_wfm,
    input  logic               load_gap,
    output logic [BURST_W-1:0] fill_bursts,      // bursts per waveform for this fill
    output logic               beat,
    output logic               burst_zero,
    output logic               gap_zero
);

    logic [1:0]         beat_div;    // 8 samples = 4 pairs = 4 cycles
    logic [BURST_W-1:0] burst_left;  // beats left after the current one
    logic [GAP_W-1:0]   gap_left;

    assign beat       = (beat_div == 2'd3);
    assign burst_zero = (burst_left == '0);
    assign gap_zero   = (gap_left == '0);  // zero gap loads zero, so high at once

    //////////////////// fill size mux
    always_ff @(posedge adc_clk) begin
        case (fill_type)
            FILL_MUON:  fill_bursts <= num_muon_bursts;
            FILL_LASER: fill_bursts <= num_laser_bursts;
            FILL_PED:   fill_bursts <= num_ped_bursts;
            default:    fill_bursts <= '0;
        endcase
    end

    //////////////////// counters
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            beat_div   <= '0;
            burst_left <= '0;
            gap_left   <= '0;
        end else begin
            beat_div <= load_wfm ? 2'd0 : beat_div + 2'd1;  // first beat 4 cycles on
            if (load_wfm)
                burst_left <= fill_bursts - BURST_W'(1);
            else if (beat && !burst_zero)
                burst_left <= burst_left - BURST_W'(1);
            if (load_gap)
                gap_left <= waveform_gap;
            else if (!gap_zero)
                gap_left <= gap_left - GAP_W'(1);  // holds at zero
        end
    end

endmodule

/* acq_ctrl_if.sv */
`timescale 1ns/100ps

interface acq_ctrl_if
    import acq_pkg::*;
#(
    parameter int WFM_W = 12
) ();

    word_sel_t        word_sel;       // which word the mux formats next
    logic             dummy_restart;  // clear the dummy counter
    fill_type_t       fill_type;      // captured at the trigger
    logic [WFM_W-1:0] waveform_num;   // current waveform in the fill

    modport sm (
        output word_sel,
        output dummy_restart,
        output fill_type
    );

    modport cnt (output waveform_num);

    modport pipe (input dummy_restart);

    modport mux (
        input word_sel,
        input fill_type,
        input waveform_num
    );

endinterface

/* acq_event_cntr.sv */
`timescale 1ns/100ps

module acq_event_cntr #(
    parameter int WFM_W  = 12,
    parameter int FILL_W = 24
) (
    input  logic              adc_clk,
    input  logic              dummy_dat_reset,
    input  logic [WFM_W-1:0]  num_waveforms,        // waveforms per trigger
    input  logic [FILL_W-1:0] initial_fill_num,
    input  logic              initial_fill_num_wr,  // load strobe for initial_fill_num
    input  logic              start_fill,
    input  logic              wfm_end,
    input  logic              fill_end,
    output logic [FILL_W-1:0] fill_num,
    output logic              last_wfm,
    acq_ctrl_if.cnt           ctrl
);

    // compare before the increment so the last waveform is known in ST_DATA
    assign last_wfm = ((ctrl.waveform_num + WFM_W'(1)) == num_waveforms);

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            ctrl.waveform_num <= '0;
            fill_num          <= '0;
        end else begin
            if (start_fill)
                ctrl.waveform_num <= '0;
            else if (wfm_end)
                ctrl.waveform_num <= ctrl.waveform_num + WFM_W'(1);
            if (initial_fill_num_wr)
                fill_num <= initial_fill_num;  // write wins over a fill end
            else if (fill_end)
                fill_num <= fill_num + FILL_W'(1);
        end
    end

endmodule

/* acq_pkg.sv */
package acq_pkg;

    //////////////////// widths
    localparam int SAMPLE_W       = 12;                // one adc sample
    localparam int PAIR_W         = 2 * SAMPLE_W + 2;  // two samples and two over-range flags
    localparam int PAIRS_PER_WORD = 4;                 // pairs in one data word
    localparam int ACQ_WORD_W     = 128;               // output word

    //////////////////// channel_tag bits
    localparam int TAG_DUMMY_BIT   = 3;  // selects dummy data instead of the adc pins
    localparam int TAG_RESTART_BIT = 4;  // restarts the dummy counter at each waveform

    // packed pair: [0] ovr0, [12:1] sample0, [13] ovr1, [25:14] sample1
    typedef logic [PAIR_W-1:0]     pair_t;
    typedef logic [ACQ_WORD_W-1:0] acq_word_t;

    // value is {acq_enable1, acq_enable0}
    typedef enum logic [1:0] {
        FILL_NONE  = 2'b00,
        FILL_MUON  = 2'b01,
        FILL_LASER = 2'b10,
        FILL_PED   = 2'b11
    } fill_type_t;

    typedef enum logic [1:0] {
        WSEL_NONE     = 2'd0,  // nothing goes out
        WSEL_FILL_HDR = 2'd1,
        WSEL_WFM_HDR  = 2'd2,
        WSEL_DATA     = 2'd3
    } word_sel_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL_HDR,
        ST_WFM_HDR,
        ST_DATA,
        ST_GAP,
        ST_DONE
    } acq_state_t;

endpackage

/* acq_sample_pipe.sv */
`timescale 1ns/100ps

module acq_sample_pipe
    import acq_pkg::*;
(
    input  logic                       adc_clk,
    input  logic                       dummy_dat_reset,
    input  pair_t                      adc_dat,      // packed pair from the pins
    input  logic [15:0]                channel_tag,
    output pair_t [PAIRS_PER_WORD-1:0] pairs,        // [0] oldest
    acq_ctrl_if.pipe                   ctrl
);

    logic [SAMPLE_W-1:0] dummy_cnt;  // integrity pattern

    //////////////////// dummy counter
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset || ctrl.dummy_restart)
            dummy_cnt <= '0;
        else
            dummy_cnt <= dummy_cnt + SAMPLE_W'(1);  // every adc_clk
    end

    //////////////////// pair pipeline
    always_ff @(posedge adc_clk) begin
        if (channel_tag[TAG_DUMMY_BIT])
            pairs[PAIRS_PER_WORD-1] <= {~dummy_cnt, 1'b0, dummy_cnt, 1'b0};  // ovr flags 0
        else
            pairs[PAIRS_PER_WORD-1] <= adc_dat;
        pairs[PAIRS_PER_WORD-2:0] <= pairs[PAIRS_PER_WORD-1:1];  // shift toward 0
    end

endmodule

/* acq_sm.sv */
`timescale 1ns/100ps

module acq_sm
    import acq_pkg::*;
(
    input  logic        adc_clk,
    input  logic        dummy_dat_reset,  // sync, active high
    input  logic        acq_enable0,      // muon, or pedestal with enable1
    input  logic        acq_enable1,      // laser, or pedestal with enable0
    input  logic        acq_trig,
    input  logic [15:0] channel_tag,
    input  logic        beat,             // one burst slot every 4 cycles
    input  logic        burst_zero,       // this beat is the last of the waveform
    input  logic        gap_zero,         // idle gap has elapsed
    input  logic        last_wfm,         // current waveform is the final one
    output logic        load_wfm,
    output logic        load_gap,
    output logic        start_fill,
    output logic        wfm_end,
    output logic        fill_end,
    output logic        acq_done,
    output logic        sm_idle,
    acq_ctrl_if.sm      ctrl
);

    acq_state_t state;
    logic       trig_ok;    // trigger accepted this cycle
    logic       last_beat;  // final data beat of a waveform
    logic       done_d;     // lines acq_done up behind the last word

    assign trig_ok   = (state == ST_IDLE) && acq_trig && (acq_enable0 || acq_enable1);
    assign last_beat = (state == ST_DATA) && beat && burst_zero;

    assign start_fill = (state == ST_FILL_HDR);  // clear waveform number
    assign load_wfm   = (state == ST_WFM_HDR);   // restart beat and burst count
    assign load_gap   = last_beat;
    assign wfm_end    = last_beat;                // advance waveform number
    assign fill_end   = (state == ST_DONE);       // advance fill number
    assign sm_idle    = (state == ST_IDLE);

    assign ctrl.dummy_restart = (state == ST_WFM_HDR) && channel_tag[TAG_RESTART_BIT];

    //////////////////// state register
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (trig_ok)
                        state <= ST_FILL_HDR;
                end
                ST_FILL_HDR: state <= ST_WFM_HDR;  // one cycle
                ST_WFM_HDR:  state <= ST_DATA;     // one cycle
                ST_DATA: begin
                    if (last_beat)
                        state <= last_wfm ? ST_DONE : ST_GAP;
                end
                ST_GAP: begin
                    if (gap_zero)
                        state <= ST_WFM_HDR;
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////// steering to the data path
    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            ctrl.word_sel  <= WSEL_NONE;
            ctrl.fill_type <= FILL_NONE;
            done_d         <= 1'b0;
            acq_done       <= 1'b0;
        end else begin
            done_d   <= fill_end;  // same two-cycle delay as the word path
            acq_done <= done_d;
            if (trig_ok)
                ctrl.fill_type <= fill_type_t'({acq_enable1, acq_enable0});
            case (state)
                ST_FILL_HDR: ctrl.word_sel <= WSEL_FILL_HDR;
                ST_WFM_HDR:  ctrl.word_sel <= WSEL_WFM_HDR;
                ST_DATA:     ctrl.word_sel <= beat ? WSEL_DATA : WSEL_NONE;
                default:     ctrl.word_sel <= WSEL_NONE;
            endcase
        end
    end

endmodule

/* acq_word_mux.sv */
`timescale 1ns/100ps

module acq_word_mux
    import acq_pkg::*;
#(
    parameter int BURST_W = 23,
    parameter int GAP_W   = 22,
    parameter int WFM_W   = 12,
    parameter int FILL_W  = 24
) (
    input  logic                       adc_clk,
    input  logic                       dummy_dat_reset,
    input  pair_t [PAIRS_PER_WORD-1:0] pairs,
    input  logic [15:0]                channel_tag,
    input  logic [FILL_W-1:0]          fill_num,
    input  logic [BURST_W-1:0]         fill_bursts,
    input  logic [WFM_W-1:0]           num_waveforms,
    input  logic [GAP_W-1:0]           waveform_gap,
    output acq_word_t                  out_dat,
    output logic                       out_valid,
    acq_ctrl_if.mux                    ctrl
);

    acq_word_t fill_hdr;
    acq_word_t wfm_hdr;
    acq_word_t data_word;

    // zero extended above the top field
    assign fill_hdr  = acq_word_t'({waveform_gap, num_waveforms, fill_bursts,
                                    ctrl.fill_type, channel_tag, fill_num});
    assign wfm_hdr   = acq_word_t'({ctrl.waveform_num, channel_tag, fill_num});
    assign data_word = acq_word_t'(pairs);  // pair 0 in the low bits

    always_ff @(posedge adc_clk) begin
        case (ctrl.word_sel)
            WSEL_FILL_HDR: out_dat <= fill_hdr;
            WSEL_WFM_HDR:  out_dat <= wfm_hdr;
            WSEL_DATA:     out_dat <= data_word;
            default:       out_dat <= '0;
        endcase
    end

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset)
            out_valid <= 1'b0;
        else
            out_valid <= (ctrl.word_sel != WSEL_NONE);  // aligned with out_dat
    end

endmodule

/* adc_acq_top.sv */
`timescale 1ns/100ps

module adc_acq_top
    import acq_pkg::*;
#(
    parameter int BURST_W = 23,
    parameter int GAP_W   = 22,
    parameter int WFM_W   = 12,
    parameter int FILL_W  = 24
) (
    input  logic               adc_clk,
    input  logic               dummy_dat_reset,
    input  pair_t              adc_dat,              // sampled pair, 26 bits
    input  logic [15:0]        channel_tag,          // header info and dummy controls
    input  logic [BURST_W-1:0] num_muon_bursts,
    input  logic [BURST_W-1:0] num_laser_bursts,
    input  logic [BURST_W-1:0] num_ped_bursts,
    input  logic [FILL_W-1:0]  initial_fill_num,
    input  logic               initial_fill_num_wr,
    input  logic               acq_enable0,
    input  logic               acq_enable1,
    input  logic               acq_trig,
    input  logic [WFM_W-1:0]   num_waveforms,
    input  logic [GAP_W-1:0]   waveform_gap,
    output logic               acq_enabled,          // acquisition rather than readout
    output logic [FILL_W-1:0]  fill_num,
    output acq_word_t          adc_acq_out_dat,
    output logic               adc_acq_out_valid,
    output logic               acq_done,
    output logic               adc_acq_sm_idle       // front panel status
);

    logic [BURST_W-1:0]         fill_bursts;
    logic                       beat;
    logic                       burst_zero;
    logic                       gap_zero;
    logic                       load_wfm;
    logic                       load_gap;
    logic                       start_fill;
    logic                       wfm_end;
    logic                       fill_end;
    logic                       last_wfm;
    pair_t [PAIRS_PER_WORD-1:0] pairs;

    assign acq_enabled = acq_enable0 | acq_enable1;

    acq_ctrl_if #(.WFM_W(WFM_W)) ctrl ();

    //////////////////// control
    acq_sm u_sm (
        .adc_clk, .dummy_dat_reset,
        .acq_enable0, .acq_enable1, .acq_trig, .channel_tag,
        .beat, .burst_zero, .gap_zero, .last_wfm,
        .load_wfm, .load_gap, .start_fill, .wfm_end, .fill_end,
        .acq_done,
        .sm_idle (adc_acq_sm_idle),
        .ctrl    (ctrl.sm)
    );

    acq_burst_timer #(.BURST_W(BURST_W), .GAP_W(GAP_W)) u_timer (
        .adc_clk, .dummy_dat_reset,
        .fill_type (ctrl.fill_type),
        .num_muon_bursts, .num_laser_bursts, .num_ped_bursts, .waveform_gap,
        .load_wfm, .load_gap,
        .fill_bursts, .beat, .burst_zero, .gap_zero
    );

    acq_event_cntr #(.WFM_W(WFM_W), .FILL_W(FILL_W)) u_cntr (
        .adc_clk, .dummy_dat_reset,
        .num_waveforms, .initial_fill_num, .initial_fill_num_wr,
        .start_fill, .wfm_end, .fill_end,
        .fill_num, .last_wfm,
        .ctrl (ctrl.cnt)
    );

    //////////////////// data path
    acq_sample_pipe u_pipe (
        .adc_clk, .dummy_dat_reset,
        .adc_dat, .channel_tag, .pairs,
        .ctrl (ctrl.pipe)
    );

    acq_word_mux #(
        .BURST_W (BURST_W),
        .GAP_W   (GAP_W),
        .WFM_W   (WFM_W),
        .FILL_W  (FILL_W)
    ) u_mux (
        .adc_clk, .dummy_dat_reset,
        .pairs, .channel_tag, .fill_num, .fill_bursts, .num_waveforms, .waveform_gap,
        .out_dat   (adc_acq_out_dat),
        .out_valid (adc_acq_out_valid),
        .ctrl      (ctrl.mux)
    );

endmodule

/* sources.f */
acq_pkg.sv
acq_ctrl_if.sv
acq_sm.sv
acq_burst_timer.sv
acq_event_cntr.sv
acq_sample_pipe.sv
acq_word_mux.sv
adc_acq_top.sv
tb_adc_acq.sv

/* tb_adc_acq.sv */
`timescale 1ns/100ps

module tb_adc_acq
    import acq_pkg::*;
();

    localparam int BURST_W = 23;
    localparam int GAP_W   = 22;
    localparam int WFM_W   = 12;
    localparam int FILL_W  = 24;
    localparam int NTEST   = 6;  // entry 0 is the trigger with both enables low

    logic               adc_clk;
    logic               dummy_dat_reset;
    pair_t              adc_dat;
    logic [15:0]        channel_tag;
    logic [BURST_W-1:0] num_muon_bursts;
    logic [BURST_W-1:0] num_laser_bursts;
    logic [BURST_W-1:0] num_ped_bursts;
    logic [FILL_W-1:0]  initial_fill_num;
    logic               initial_fill_num_wr;
    logic               acq_enable0;
    logic               acq_enable1;
    logic               acq_trig;
    logic [WFM_W-1:0]   num_waveforms;
    logic [GAP_W-1:0]   waveform_gap;
    logic               acq_enabled;
    logic [FILL_W-1:0]  fill_num;
    acq_word_t          adc_acq_out_dat;
    logic               adc_acq_out_valid;
    logic               acq_done;
    logic               adc_acq_sm_idle;

    string       t_name [NTEST];
    logic [1:0]  t_en [NTEST];     // {enable1, enable0}
    logic [15:0] t_tag [NTEST];
    int          t_w [NTEST];      // waveforms per fill
    int          t_g [NTEST];      // gap cycles
    int          t_b [NTEST][4];   // bursts indexed by fill type

    logic [11:0]       sample_cnt;  // pin data counter
    logic              busy;        // reference fill in progress
    fill_type_t        exp_type;
    logic [FILL_W-1:0] exp_fill;
    logic [2:0]        trig_sr;     // accepted trigger history
    logic              trig_acc;
    int                word_idx;    // valid words seen in this fill
    int                burst_n;
    int                total;
    int                slot;        // 0 is the waveform header
    int                wfm_n;
    logic              is_data;
    logic [11:0]       data_cnt;    // first sample of pair 0
    logic [11:0]       prev_cnt;
    logic [11:0]       first_cnt;   // first data word of the fill
    acq_word_t         exp_word;
    int                err_cnt = 0;
    int                budget  = 0;

    adc_acq_top #(.BURST_W(BURST_W), .GAP_W(GAP_W), .WFM_W(WFM_W), .FILL_W(FILL_W)) uut (.*);

    initial begin
        adc_clk = 1'b0;
        forever #2 adc_clk = ~adc_clk;
    end

    always @(posedge adc_clk) begin
        adc_dat    <= {12'(sample_cnt + 12'd1), 1'b0, sample_cnt, 1'b0};  // two samples per cycle
        sample_cnt <= sample_cnt + 12'd2;
    end

    //////////////////// reference model
    function automatic pair_t make_pair(input logic [11:0] c0, input int p, input logic dummy);
        logic [11:0] s;
        if (dummy) begin
            s = c0 + 12'(p);  // dummy counter steps once per pair
            return {~s, 1'b0, s, 1'b0};
        end
        s = c0 + 12'(2 * p);
        return {12'(s + 12'd1), 1'b0, s, 1'b0};
    endfunction

    assign trig_acc = acq_trig && (acq_enable0 || acq_enable1) && !busy;

    always_comb begin
        case (exp_type)
            FILL_MUON:  burst_n = int'(num_muon_bursts);
            FILL_LASER: burst_n = int'(num_laser_bursts);
            FILL_PED:   burst_n = int'(num_ped_bursts);
            default:    burst_n = 0;
        endcase
        total    = 1 + int'(num_waveforms) * (burst_n + 1);
        slot     = (word_idx == 0) ? 0 : (word_idx - 1) % (burst_n + 1);
        wfm_n    = (word_idx == 0) ? 0 : (word_idx - 1) / (burst_n + 1);
        is_data  = (word_idx != 0) && (slot != 0);
        data_cnt = adc_acq_out_dat[12:1];
        exp_word = '0;
        if (word_idx == 0) begin  // fill header
            exp_word[23:0]  = exp_fill;
            exp_word[39:24] = channel_tag;
            exp_word[41:40] = exp_type;
            exp_word[64:42] = BURST_W'(burst_n);
            exp_word[76:65] = num_waveforms;
            exp_word[98:77] = waveform_gap;
        end else if (!is_data) begin  // waveform header
            exp_word[23:0]  = exp_fill;
            exp_word[39:24] = channel_tag;
            exp_word[51:40] = WFM_W'(wfm_n);
        end else begin
            for (int p = 0; p < PAIRS_PER_WORD; p++)
                exp_word[p*26 +: 26] = make_pair(data_cnt, p, channel_tag[TAG_DUMMY_BIT]);
        end
    end

    always @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            busy     <= 1'b0;
            exp_type <= FILL_NONE;
            exp_fill <= '0;
            trig_sr  <= '0;
            word_idx <= 0;
        end else begin
            trig_sr <= {trig_sr[1:0], trig_acc};
            if (trig_acc) begin
                busy     <= 1'b1;
                exp_type <= fill_type_t'({acq_enable1, acq_enable0});
            end
            if (initial_fill_num_wr)
                exp_fill <= initial_fill_num;
            if (adc_acq_out_valid) begin
                word_idx <= word_idx + 1;
                if (is_data)
                    prev_cnt <= data_cnt;
                if (is_data && slot == 1 && wfm_n == 0)
                    first_cnt <= data_cnt;
            end
            if (acq_done) begin  // fill closed
                busy     <= 1'b0;
                word_idx <= 0;
                exp_fill <= exp_fill + FILL_W'(1);
            end
        end
    end

    //////////////////// checks
    task automatic report_value(input string sig, input acq_word_t got, input acq_word_t exp);
        err_cnt++;
        $display("CHECK FAILED t=%0t %s got %h exp %h", $time, sig, got, exp);
    endtask

    task automatic report_text(input string what);
        err_cnt++;
        $display("error at t=%0t: %s", $time, what);
    endtask

    a_hdr_time: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        (adc_acq_out_valid && word_idx == 0) == trig_sr[2])
        else report_value("fill header valid", acq_word_t'($sampled(adc_acq_out_valid)),
                          acq_word_t'($sampled(trig_sr[2])));
    a_word: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        adc_acq_out_valid |-> adc_acq_out_dat == exp_word)
        else report_value("adc_acq_out_dat", $sampled(adc_acq_out_dat), $sampled(exp_word));
    a_count: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        adc_acq_out_valid |-> busy && word_idx < total)
        else report_text("a valid word came outside a fill or after its last word");
    a_done: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        acq_done |-> word_idx == total)
        else report_value("words before acq_done", acq_word_t'($sampled(word_idx)),
                          acq_word_t'($sampled(total)));
    a_fill_inc: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        acq_done |-> fill_num == FILL_W'(exp_fill + FILL_W'(1)))
        else report_value("fill_num", acq_word_t'($sampled(fill_num)),
                          acq_word_t'($sampled(exp_fill) + FILL_W'(1)));
    a_fill_idle: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        !busy |-> fill_num == exp_fill)
        else report_value("fill_num", acq_word_t'($sampled(fill_num)),
                          acq_word_t'($sampled(exp_fill)));
    a_idle: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        !busy |-> adc_acq_sm_idle)
        else report_text("adc_acq_sm_idle is low with no fill running");
    a_enabled: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        acq_enabled == (acq_enable0 | acq_enable1))
        else report_text("acq_enabled does not follow the two enables");
    a_dummy_step: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        (adc_acq_out_valid && is_data && channel_tag[TAG_DUMMY_BIT]
            && !channel_tag[TAG_RESTART_BIT] && slot > 1) |-> data_cnt == 12'(prev_cnt + 12'd4))
        else report_value("dummy count", acq_word_t'($sampled(data_cnt)),
                          acq_word_t'(12'($sampled(prev_cnt) + 12'd4)));
    a_dummy_restart: assert property (@(posedge adc_clk) disable iff (dummy_dat_reset)
        (adc_acq_out_valid && is_data && channel_tag[TAG_DUMMY_BIT]
            && channel_tag[TAG_RESTART_BIT] && slot == 1 && wfm_n > 0) |-> data_cnt == first_cnt)
        else report_value("restarted dummy count", acq_word_t'($sampled(data_cnt)),
                          acq_word_t'($sampled(first_cnt)));

    //////////////////// stimulus
    task automatic make_tests();
        t_name = '{"disabled", "muon", "laser", "pedestal", "dummy", "dummy restart"};
        t_en   = '{2'b00, 2'b01, 2'b10, 2'b11, 2'b01, 2'b10};
        for (int i = 0; i < NTEST; i++) begin
            t_w[i]     = (i == 0) ? 0 : int'($urandom_range(3, 2));
            t_g[i]     = int'($urandom_range(5, 0));
            t_b[i][0]  = 0;
            for (int f = 1; f < 4; f++)
                t_b[i][f] = int'($urandom_range(4, 2));
            t_tag[i]   = 16'($urandom);
            t_tag[i][TAG_DUMMY_BIT]   = (i >= 4);
            t_tag[i][TAG_RESTART_BIT] = (i == 5);
            budget += 2 * (t_w[i] * (t_b[i][t_en[i]] * 4 + t_g[i] + 4) + 10);
        end
    endtask

    task automatic run_test(input int i);
        int errs_before;
        errs_before      = err_cnt;
        channel_tag      <= t_tag[i];
        num_muon_bursts  <= BURST_W'(t_b[i][1]);
        num_laser_bursts <= BURST_W'(t_b[i][2]);
        num_ped_bursts   <= BURST_W'(t_b[i][3]);
        num_waveforms    <= WFM_W'(t_w[i]);
        waveform_gap     <= GAP_W'(t_g[i]);
        {acq_enable1, acq_enable0} <= t_en[i];
        repeat (2) @(posedge adc_clk);
        acq_trig <= 1'b1;
        @(posedge adc_clk);
        acq_trig <= 1'b0;
        if (t_en[i] == 2'b00)
            repeat (8) @(posedge adc_clk);  // must stay silent
        else
            do @(posedge adc_clk); while (!acq_done);
        $display("test %0d (%s) finished: W=%0d gap=%0d, %0d failed checks",
                 i, t_name[i], t_w[i], t_g[i], err_cnt - errs_before);
    endtask

    initial begin
        void'($urandom(83));
        dummy_dat_reset     = 1'b1;
        sample_cnt          = 12'($urandom);
        adc_dat             = '0;
        channel_tag         = '0;
        num_muon_bursts     = '0;
        num_laser_bursts    = '0;
        num_ped_bursts      = '0;
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        acq_enable0         = 1'b0;
        acq_enable1         = 1'b0;
        acq_trig            = 1'b0;
        num_waveforms       = '0;
        waveform_gap        = '0;
        make_tests();
        repeat (3) @(posedge adc_clk);
        dummy_dat_reset <= 1'b0;
        @(posedge adc_clk);
        initial_fill_num    <= FILL_W'($urandom);
        initial_fill_num_wr <= 1'b1;
        @(posedge adc_clk);
        initial_fill_num_wr <= 1'b0;
        for (int i = 0; i < NTEST; i++)
            run_test(i);
        repeat (4) @(posedge adc_clk);
        $display("tests run %0d, failed checks %0d", NTEST, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge adc_clk);
        $display("watchdog expired after %0d cycles before all fills completed", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule
